//--- aes_ctrl_pkg.sv
// Package with sparse codes, select codes, key lengths, round counts and rail FSM states
`default_nettype none

package aes_ctrl_pkg;

  ////////////////////////////////////////
  // Sparse two-value words
  ////////////////////////////////////////

  localparam int unsigned Sp2VWidth = 3;

  localparam logic [Sp2VWidth-1:0] SP2V_HIGH = 3'b011;
  localparam logic [Sp2VWidth-1:0] SP2V_LOW  = 3'b100;

  // Bit i is 1 when the word is asserted, so rail i works in true logic
  localparam logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

  // Words checked at the top level: in_valid, out_ready, crypt register
  localparam int unsigned NumSp2VChk = 3;

  ////////////////////////////////////////
  // Key length and rounds
  ////////////////////////////////////////

  localparam int unsigned KeyLenWidth = 3;

  localparam logic [KeyLenWidth-1:0] AES_128 = 3'b001; // One-hot
  localparam logic [KeyLenWidth-1:0] AES_192 = 3'b010;
  localparam logic [KeyLenWidth-1:0] AES_256 = 3'b100;

  localparam int unsigned RndCtrWidth = 4;

  localparam logic [RndCtrWidth-1:0] NumRounds128 = 4'd10;
  localparam logic [RndCtrWidth-1:0] NumRounds192 = 4'd12;
  localparam logic [RndCtrWidth-1:0] NumRounds256 = 4'd14;

  // Operation
  localparam int unsigned CiphOpWidth = 2;

  localparam logic [CiphOpWidth-1:0] CIPH_FWD = 2'b01;
  localparam logic [CiphOpWidth-1:0] CIPH_INV = 2'b10;

  ////////////////////////////////////////
  // Data path selects
  ////////////////////////////////////////

  localparam int unsigned StateSelWidth = 3;

  localparam logic [StateSelWidth-1:0] STATE_INIT  = 3'b011;
  localparam logic [StateSelWidth-1:0] STATE_ROUND = 3'b100;

  localparam int unsigned AddRkSelWidth = 3;

  localparam logic [AddRkSelWidth-1:0] ADD_RK_INIT  = 3'b001;
  localparam logic [AddRkSelWidth-1:0] ADD_RK_ROUND = 3'b010;
  localparam logic [AddRkSelWidth-1:0] ADD_RK_FINAL = 3'b100;

  localparam int unsigned RoundKeySelWidth = 2;

  localparam logic [RoundKeySelWidth-1:0] ROUND_KEY_DIRECT = 2'b01;
  localparam logic [RoundKeySelWidth-1:0] ROUND_KEY_MIXED  = 2'b10;

  ////////////////////////////////////////
  // Rail FSM states
  ////////////////////////////////////////

  // Five codes need six bits to keep a Hamming distance of 3 between any two
  localparam int unsigned RailStateWidth = 6;

  localparam logic [RailStateWidth-1:0] ST_IDLE   = 6'b001110;
  localparam logic [RailStateWidth-1:0] ST_INIT   = 6'b110010;
  localparam logic [RailStateWidth-1:0] ST_ROUND  = 6'b010101;
  localparam logic [RailStateWidth-1:0] ST_FINISH = 6'b101001;
  localparam logic [RailStateWidth-1:0] ST_ERROR  = 6'b100100; // Terminal

endpackage

`default_nettype wire

//--- aes_sp2v_chk.sv
// Validity checker for a set of sparse two-value words with a combined error
`default_nettype none
`timescale 1ns/10ps

module aes_sp2v_chk #(
  parameter int unsigned Num = 1
) (
  input  logic [Num-1:0][aes_ctrl_pkg::Sp2VWidth-1:0] sig_i,
  output logic [Num-1:0][aes_ctrl_pkg::Sp2VWidth-1:0] sig_o,
  output logic                                        err_o
);

  logic [Num-1:0] word_high;
  logic [Num-1:0] word_low;
  logic [Num-1:0] word_err;

  // Only the two sparse codes are legal, everything else is a fault
  for (genvar i = 0; i < Num; i++) begin : gen_word_chk
    assign word_high[i] = (sig_i[i] == aes_ctrl_pkg::SP2V_HIGH);
    assign word_low[i]  = (sig_i[i] == aes_ctrl_pkg::SP2V_LOW);
    assign word_err[i]  = ~(word_high[i] | word_low[i]);
  end

  // Words go on unchanged
  assign sig_o = sig_i;

  assign err_o = |word_err; // Any bad word

endmodule

`default_nettype wire

//--- aes_rail_combine.sv
// Rail output combiner with mismatch detection on selects, counters and alerts
`default_nettype none
`timescale 1ns/10ps

module aes_rail_combine (
  // Per-rail outputs
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::StateSelWidth-1:0]
                                                     mr_state_sel_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::AddRkSelWidth-1:0]
                                                     mr_add_rk_sel_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RoundKeySelWidth-1:0]
                                                     mr_round_key_sel_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RndCtrWidth-1:0]
                                                     mr_rnd_ctr_i,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         mr_alert_i,

  // Combined outputs
  output logic [aes_ctrl_pkg::StateSelWidth-1:0]     state_sel_o,
  output logic [aes_ctrl_pkg::AddRkSelWidth-1:0]     add_rk_sel_o,
  output logic [aes_ctrl_pkg::RoundKeySelWidth-1:0]  round_key_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0]       rnd_ctr_o,
  output logic                                       alert_o,
  output logic                                       mr_err_o
);

  ////////////////////////////////////////
  // OR combining
  ////////////////////////////////////////

  // A single rail driving a bit is enough to set it
  always_comb begin : combine_rails
    state_sel_o     = '0;
    add_rk_sel_o    = '0;
    round_key_sel_o = '0;
    rnd_ctr_o       = '0;
    alert_o         = 1'b0;
    for (int i = 0; i < aes_ctrl_pkg::Sp2VWidth; i++) begin
      state_sel_o     |= mr_state_sel_i[i];
      add_rk_sel_o    |= mr_add_rk_sel_i[i];
      round_key_sel_o |= mr_round_key_sel_i[i];
      rnd_ctr_o       |= mr_rnd_ctr_i[i];
      alert_o         |= mr_alert_i[i];
    end
  end

  ////////////////////////////////////////
  // Mismatch detection
  ////////////////////////////////////////

  // A valid but disagreeing code would slip past the encoding checks,
  // so compare every rail against the OR result
  always_comb begin : compare_rails
    mr_err_o = 1'b0;
    for (int i = 0; i < aes_ctrl_pkg::Sp2VWidth; i++) begin
      if (mr_state_sel_i[i]     != state_sel_o     ||
          mr_add_rk_sel_i[i]    != add_rk_sel_o    ||
          mr_round_key_sel_i[i] != round_key_sel_o ||
          mr_rnd_ctr_i[i]       != rnd_ctr_o       ||
          mr_alert_i[i]         != alert_o) begin
        mr_err_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- aes_ctrl_rail.sv
// Single-rail cipher controller FSM with round counter and latched operation
`default_nettype none
`timescale 1ns/10ps

module aes_ctrl_rail #(
  parameter bit RailHigh = 1'b1 // 0: sparse bits are inverted
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  // Handshakes, one sparse bit each
  input  logic                                       in_valid_i,
  output logic                                       in_ready_o,
  output logic                                       out_valid_o,
  input  logic                                       out_ready_i,

  // Busy status loop through the top-level register
  input  logic                                       crypt_q_i,
  output logic                                       crypt_d_o,

  input  logic [aes_ctrl_pkg::KeyLenWidth-1:0]       key_len_i,
  input  logic [aes_ctrl_pkg::CiphOpWidth-1:0]       op_i,
  input  logic                                       enc_err_i,
  input  logic                                       mr_err_i,

  // Data path control
  output logic                                       state_we_o,
  output logic                                       key_expand_en_o,
  output logic [aes_ctrl_pkg::StateSelWidth-1:0]     state_sel_o,
  output logic [aes_ctrl_pkg::AddRkSelWidth-1:0]     add_rk_sel_o,
  output logic [aes_ctrl_pkg::RoundKeySelWidth-1:0]  round_key_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0]       rnd_ctr_o,
  output logic                                       alert_o
);

  localparam bit Inv = !RailHigh;

  logic                                      in_valid;
  logic                                      out_ready;
  logic                                      crypt_q;
  logic                                      in_ready;
  logic                                      out_valid;
  logic                                      crypt_d;
  logic                                      state_we;
  logic                                      key_expand_en;

  logic [aes_ctrl_pkg::RailStateWidth-1:0]   state_d, state_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]      rnd_ctr_d, rnd_ctr_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]      num_rounds_d, num_rounds_q;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]      num_rounds_sel;
  logic [aes_ctrl_pkg::CiphOpWidth-1:0]      op_d, op_q;
  logic                                      key_len_err;

  // Bring sparse inputs into rail logic
  assign in_valid  = in_valid_i ^ Inv;
  assign out_ready = out_ready_i ^ Inv;
  assign crypt_q   = crypt_q_i ^ Inv;

  // Round count per key length
  always_comb begin : key_len_decode
    key_len_err    = 1'b0;
    num_rounds_sel = aes_ctrl_pkg::NumRounds128;
    case (key_len_i)
      aes_ctrl_pkg::AES_128: num_rounds_sel = aes_ctrl_pkg::NumRounds128;
      aes_ctrl_pkg::AES_192: num_rounds_sel = aes_ctrl_pkg::NumRounds192;
      aes_ctrl_pkg::AES_256: num_rounds_sel = aes_ctrl_pkg::NumRounds256;
      default:               key_len_err    = 1'b1; // Not one-hot
    endcase
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin : rail_fsm
    state_d         = state_q;
    rnd_ctr_d       = rnd_ctr_q;
    num_rounds_d    = num_rounds_q;
    op_d            = op_q;

    in_ready        = 1'b0;
    out_valid       = 1'b0;
    crypt_d         = 1'b0;
    state_we        = 1'b0;
    key_expand_en   = 1'b0;
    state_sel_o     = aes_ctrl_pkg::STATE_ROUND;
    add_rk_sel_o    = aes_ctrl_pkg::ADD_RK_ROUND;
    round_key_sel_o = aes_ctrl_pkg::ROUND_KEY_DIRECT;
    alert_o         = 1'b0;

    case (state_q)
      aes_ctrl_pkg::ST_IDLE: begin
        in_ready  = 1'b1;
        rnd_ctr_d = '0;
        if (in_valid) begin
          op_d         = op_i;           // Sampled at acceptance
          num_rounds_d = num_rounds_sel;
          state_d      = key_len_err ? aes_ctrl_pkg::ST_ERROR : aes_ctrl_pkg::ST_INIT;
        end
      end

      aes_ctrl_pkg::ST_INIT: begin
        state_sel_o   = aes_ctrl_pkg::STATE_INIT;
        add_rk_sel_o  = aes_ctrl_pkg::ADD_RK_INIT;
        state_we      = 1'b1;
        key_expand_en = 1'b1;
        crypt_d       = 1'b1; // Busy from next cycle
        rnd_ctr_d     = rnd_ctr_q + 1'b1;
        state_d       = aes_ctrl_pkg::ST_ROUND;
      end

      aes_ctrl_pkg::ST_ROUND: begin
        state_we      = 1'b1;
        key_expand_en = 1'b1;
        crypt_d       = crypt_q;
        if (op_q == aes_ctrl_pkg::CIPH_INV) begin
          round_key_sel_o = aes_ctrl_pkg::ROUND_KEY_MIXED;
        end
        rnd_ctr_d = rnd_ctr_q + 1'b1;
        // Last full round
        if (rnd_ctr_q == num_rounds_q - 1'b1) begin
          state_d = aes_ctrl_pkg::ST_FINISH;
        end
      end

      aes_ctrl_pkg::ST_FINISH: begin
        out_valid    = 1'b1;
        add_rk_sel_o = aes_ctrl_pkg::ADD_RK_FINAL;
        crypt_d      = crypt_q;
        if (out_ready) begin
          state_d = aes_ctrl_pkg::ST_IDLE; // Hold under back-pressure
        end
      end

      aes_ctrl_pkg::ST_ERROR: begin
        alert_o = 1'b1; // Left only by reset
      end

      default: state_d = aes_ctrl_pkg::ST_ERROR;
    endcase

    // Any fault wins over the regular sequence
    if (enc_err_i || mr_err_i) begin
      state_d = aes_ctrl_pkg::ST_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_fsm
    if (!rst_ni) begin
      state_q      <= aes_ctrl_pkg::ST_IDLE;
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
      op_q         <= aes_ctrl_pkg::CIPH_FWD;
    end else begin
      state_q      <= state_d;
      rnd_ctr_q    <= rnd_ctr_d;
      num_rounds_q <= num_rounds_d;
      op_q         <= op_d;
    end
  end

  assign rnd_ctr_o = rnd_ctr_q;

  // Back to sparse polarity
  assign in_ready_o      = in_ready ^ Inv;
  assign out_valid_o     = out_valid ^ Inv;
  assign crypt_d_o       = crypt_d ^ Inv;
  assign state_we_o      = state_we ^ Inv;
  assign key_expand_en_o = key_expand_en ^ Inv;

endmodule

`default_nettype wire

//--- aes_cipher_control.sv
// AES cipher control top level with redundant rails, combiner, checker and crypt register
`default_nettype none
`timescale 1ns/10ps

module aes_cipher_control (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         in_valid_i,
  output logic [aes_ctrl_pkg::Sp2VWidth-1:0]         in_ready_o,
  output logic [aes_ctrl_pkg::Sp2VWidth-1:0]         out_valid_o,
  input  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         out_ready_i,

  input  logic [aes_ctrl_pkg::KeyLenWidth-1:0]       key_len_i,
  input  logic [aes_ctrl_pkg::CiphOpWidth-1:0]       op_i,
  output logic [aes_ctrl_pkg::Sp2VWidth-1:0]         crypt_o,

  output logic [aes_ctrl_pkg::Sp2VWidth-1:0]         state_we_o,
  output logic [aes_ctrl_pkg::Sp2VWidth-1:0]         key_expand_en_o,
  output logic [aes_ctrl_pkg::StateSelWidth-1:0]     state_sel_o,
  output logic [aes_ctrl_pkg::AddRkSelWidth-1:0]     add_rk_sel_o,
  output logic [aes_ctrl_pkg::RoundKeySelWidth-1:0]  round_key_sel_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0]       rnd_ctr_o,
  output logic                                       alert_o
);

  // Checked sparse words
  logic [aes_ctrl_pkg::NumSp2VChk-1:0][aes_ctrl_pkg::Sp2VWidth-1:0] chk_in, chk_out;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0] in_valid, out_ready, crypt_chk;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0] crypt_d, crypt_q;
  logic                               enc_err;
  logic                               mr_err;

  // Per-rail outputs to be combined
  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::StateSelWidth-1:0]    mr_state_sel;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::AddRkSelWidth-1:0]    mr_add_rk_sel;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RoundKeySelWidth-1:0] mr_round_key_sel;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0][aes_ctrl_pkg::RndCtrWidth-1:0]      mr_rnd_ctr;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]                                     mr_alert;

  ////////////////////////////////////////
  // Encoding checks
  ////////////////////////////////////////

  assign chk_in[0] = in_valid_i;
  assign chk_in[1] = out_ready_i;
  assign chk_in[2] = crypt_q;

  aes_sp2v_chk #(
    .Num ( aes_ctrl_pkg::NumSp2VChk )
  ) u_sp2v_chk (
    .sig_i ( chk_in  ),
    .sig_o ( chk_out ),
    .err_o ( enc_err )
  );

  assign in_valid  = chk_out[0];
  assign out_ready = chk_out[1];
  assign crypt_chk = chk_out[2];

  ////////////////////////////////////////
  // Rails
  ////////////////////////////////////////

  // One rail per sparse bit, polarity taken from the asserted code
  for (genvar i = 0; i < aes_ctrl_pkg::Sp2VWidth; i++) begin : gen_rail
    aes_ctrl_rail #(
      .RailHigh ( aes_ctrl_pkg::SP2V_LOGIC_HIGH[i] )
    ) u_rail (
      .clk_i           ( clk_i               ),
      .rst_ni          ( rst_ni              ),
      .in_valid_i      ( in_valid[i]         ),
      .in_ready_o      ( in_ready_o[i]       ),
      .out_valid_o     ( out_valid_o[i]      ),
      .out_ready_i     ( out_ready[i]        ),
      .crypt_q_i       ( crypt_chk[i]        ),
      .crypt_d_o       ( crypt_d[i]          ),
      .key_len_i       ( key_len_i           ),
      .op_i            ( op_i                ),
      .enc_err_i       ( enc_err             ),
      .mr_err_i        ( mr_err              ),
      .state_we_o      ( state_we_o[i]       ),
      .key_expand_en_o ( key_expand_en_o[i]  ),
      .state_sel_o     ( mr_state_sel[i]     ), // OR-combined
      .add_rk_sel_o    ( mr_add_rk_sel[i]    ),
      .round_key_sel_o ( mr_round_key_sel[i] ),
      .rnd_ctr_o       ( mr_rnd_ctr[i]       ),
      .alert_o         ( mr_alert[i]         )
    );
  end

  aes_rail_combine u_rail_combine (
    .mr_state_sel_i     ( mr_state_sel     ),
    .mr_add_rk_sel_i    ( mr_add_rk_sel    ),
    .mr_round_key_sel_i ( mr_round_key_sel ),
    .mr_rnd_ctr_i       ( mr_rnd_ctr       ),
    .mr_alert_i         ( mr_alert         ),
    .state_sel_o        ( state_sel_o      ),
    .add_rk_sel_o       ( add_rk_sel_o     ),
    .round_key_sel_o    ( round_key_sel_o  ),
    .rnd_ctr_o          ( rnd_ctr_o        ),
    .alert_o            ( alert_o          ),
    .mr_err_o           ( mr_err           )  // Back into all rails
  );

  // Busy status register, idle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_crypt
    if (!rst_ni) begin
      crypt_q <= aes_ctrl_pkg::SP2V_LOW;
    end else begin
      crypt_q <= crypt_d;
    end
  end

  assign crypt_o = crypt_q;

endmodule

`default_nettype wire

//--- aes_cipher_control_props.sv
// Concurrent assertions on the cipher control ports and their bind statement
`default_nettype none
`timescale 1ns/10ps

module aes_cipher_control_props (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic [aes_ctrl_pkg::Sp2VWidth-1:0]     in_ready_i,
  input logic [aes_ctrl_pkg::Sp2VWidth-1:0]     out_valid_i,
  input logic [aes_ctrl_pkg::Sp2VWidth-1:0]     out_ready_i,
  input logic [aes_ctrl_pkg::AddRkSelWidth-1:0] add_rk_sel_i,
  input logic                                   alert_i
);

  // Never accepting and delivering at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_ready_i == aes_ctrl_pkg::SP2V_HIGH && out_valid_i == aes_ctrl_pkg::SP2V_HIGH))
    else $error("in_ready and out_valid both asserted");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> alert_i)
    else $error("alert dropped without reset");

  // Output stays put under back-pressure unless a fault hits
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_i == aes_ctrl_pkg::SP2V_HIGH && out_ready_i == aes_ctrl_pkg::SP2V_LOW)
    |=> alert_i || ($stable(out_valid_i) && $stable(add_rk_sel_i)))
    else $error("out_valid or add_rk_sel changed under back-pressure");

endmodule

bind aes_cipher_control aes_cipher_control_props u_props (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .in_ready_i   ( in_ready_o   ),
  .out_valid_i  ( out_valid_o  ),
  .out_ready_i  ( out_ready_i  ),
  .add_rk_sel_i ( add_rk_sel_o ),
  .alert_i      ( alert_o      )
);

`default_nettype wire

//--- aes_cipher_control_tb.sv
// Testbench for the cipher control unit with stimulus table, LFSR delays, checks and watchdog
`default_nettype none
`timescale 1ns/10ps

module aes_cipher_control_tb;

  localparam int NumRows   = 8;
  localparam int RstCycles = 5;

  logic                                       clk;
  logic                                       rst_n;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         in_valid;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         in_ready;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         out_valid;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         out_ready;
  logic [aes_ctrl_pkg::KeyLenWidth-1:0]       key_len;
  logic [aes_ctrl_pkg::CiphOpWidth-1:0]       op;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         crypt;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         state_we;
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]         key_expand_en;
  logic [aes_ctrl_pkg::StateSelWidth-1:0]     state_sel;
  logic [aes_ctrl_pkg::AddRkSelWidth-1:0]     add_rk_sel;
  logic [aes_ctrl_pkg::RoundKeySelWidth-1:0]  round_key_sel;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]       rnd_ctr;
  logic                                       alert;

  // Stimulus table, one entry per block
  logic [aes_ctrl_pkg::Sp2VWidth-1:0]   row_valid   [NumRows];
  logic [aes_ctrl_pkg::KeyLenWidth-1:0] row_key_len [NumRows];
  logic [aes_ctrl_pkg::CiphOpWidth-1:0] row_op      [NumRows];
  logic [2:0]                           row_delay   [NumRows]; // out_ready back-pressure
  logic                                 row_alert   [NumRows];

  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          cycle_limit;

  aes_cipher_control dut0 (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .in_valid_i      ( in_valid      ),
    .in_ready_o      ( in_ready      ),
    .out_valid_o     ( out_valid     ),
    .out_ready_i     ( out_ready     ),
    .key_len_i       ( key_len       ),
    .op_i            ( op            ),
    .crypt_o         ( crypt         ),
    .state_we_o      ( state_we      ),
    .key_expand_en_o ( key_expand_en ),
    .state_sel_o     ( state_sel     ),
    .add_rk_sel_o    ( add_rk_sel    ),
    .round_key_sel_o ( round_key_sel ),
    .rnd_ctr_o       ( rnd_ctr       ),
    .alert_o         ( alert         )
  );

  always #50 clk = ~clk; // 100 ns period

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int rounds_for(input logic [aes_ctrl_pkg::KeyLenWidth-1:0] klen);
    case (klen)
      aes_ctrl_pkg::AES_192: rounds_for = 12;
      aes_ctrl_pkg::AES_256: rounds_for = 14;
      default:               rounds_for = 10; // Also the bound for bad codes
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic set_row(input int idx, input logic [2:0] valid, input logic [2:0] klen,
                         input logic [1:0] opc, input logic alrt);
    logic [2:0] d;
    d = '0;
    for (int b = 0; b < 3; b++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      d = {d[1:0], lfsr_state[0]};
    end
    row_valid[idx]   = valid;
    row_key_len[idx] = klen;
    row_op[idx]      = opc;
    row_delay[idx]   = d;
    row_alert[idx]   = alrt;
  endtask

  task automatic check_finish();
    check_val("out_valid_o", aes_ctrl_pkg::SP2V_HIGH, out_valid);
    check_val("add_rk_sel_o", aes_ctrl_pkg::ADD_RK_FINAL, add_rk_sel);
    check_val("round_key_sel_o", aes_ctrl_pkg::ROUND_KEY_DIRECT, round_key_sel);
    check_val("crypt_o", aes_ctrl_pkg::SP2V_HIGH, crypt);
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_LOW, in_ready);
    check_val("state_we_o", aes_ctrl_pkg::SP2V_LOW, state_we);
    check_val("key_expand_en_o", aes_ctrl_pkg::SP2V_LOW, key_expand_en);
  endtask

  ////////////////////////////////////////
  // Block and fault sequences
  ////////////////////////////////////////

  task automatic run_block(input int idx);
    int                                        nr;
    int                                        steps;
    logic [aes_ctrl_pkg::RoundKeySelWidth-1:0] exp_rk;
    nr     = rounds_for(row_key_len[idx]);
    exp_rk = (row_op[idx] == aes_ctrl_pkg::CIPH_INV) ? aes_ctrl_pkg::ROUND_KEY_MIXED
                                                     : aes_ctrl_pkg::ROUND_KEY_DIRECT;
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_HIGH, in_ready);
    in_valid = row_valid[idx];
    key_len  = row_key_len[idx];
    op       = row_op[idx];
    next_cycle(); // Acceptance edge
    in_valid = aes_ctrl_pkg::SP2V_LOW;
    op       = ~row_op[idx]; // Latched copy must not follow

    // INIT step
    check_val("state_sel_o", aes_ctrl_pkg::STATE_INIT, state_sel);
    check_val("add_rk_sel_o", aes_ctrl_pkg::ADD_RK_INIT, add_rk_sel);
    check_val("round_key_sel_o", aes_ctrl_pkg::ROUND_KEY_DIRECT, round_key_sel);
    check_val("rnd_ctr_o", 0, rnd_ctr);
    check_val("state_we_o", aes_ctrl_pkg::SP2V_HIGH, state_we);
    check_val("key_expand_en_o", aes_ctrl_pkg::SP2V_HIGH, key_expand_en);
    check_val("crypt_o", aes_ctrl_pkg::SP2V_LOW, crypt);
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_LOW, in_ready);

    next_cycle();
    steps = 1;
    while (out_valid !== aes_ctrl_pkg::SP2V_HIGH) begin
      check_val("state_sel_o", aes_ctrl_pkg::STATE_ROUND, state_sel);
      check_val("add_rk_sel_o", aes_ctrl_pkg::ADD_RK_ROUND, add_rk_sel);
      check_val("round_key_sel_o", exp_rk, round_key_sel);
      check_val("rnd_ctr_o", steps, rnd_ctr);
      check_val("crypt_o", aes_ctrl_pkg::SP2V_HIGH, crypt);
      check_val("state_we_o", aes_ctrl_pkg::SP2V_HIGH, state_we);
      check_val("key_expand_en_o", aes_ctrl_pkg::SP2V_HIGH, key_expand_en);
      check_val("in_ready_o", aes_ctrl_pkg::SP2V_LOW, in_ready);
      next_cycle();
      steps++;
    end
    check_val("out_valid_o latency", nr, steps);

    // FINISH holds until out_ready
    for (int c = 0; c <= int'(row_delay[idx]); c++) begin
      check_finish();
      if (c == int'(row_delay[idx])) out_ready = aes_ctrl_pkg::SP2V_HIGH;
      next_cycle();
    end
    out_ready = aes_ctrl_pkg::SP2V_LOW;
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_HIGH, in_ready);
    check_val("out_valid_o", aes_ctrl_pkg::SP2V_LOW, out_valid);
    check_val("crypt_o", aes_ctrl_pkg::SP2V_HIGH, crypt); // Register lags by one
    next_cycle();
    check_val("crypt_o", aes_ctrl_pkg::SP2V_LOW, crypt);
    check_val("alert_o", 0, alert);
  endtask

  task automatic run_fault(input int idx);
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_HIGH, in_ready);
    in_valid = row_valid[idx];
    key_len  = row_key_len[idx];
    op       = row_op[idx];
    next_cycle();
    in_valid = aes_ctrl_pkg::SP2V_LOW;
    key_len  = aes_ctrl_pkg::AES_128;
    check_val("alert_o", 1, alert);
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_LOW, in_ready);
    check_val("out_valid_o", aes_ctrl_pkg::SP2V_LOW, out_valid);
    next_cycle();
    check_val("alert_o", 1, alert); // Terminal
    rst_n = 1'b0;
    repeat (2) next_cycle();
    rst_n = 1'b1;
    check_val("alert_o", 0, alert);
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_HIGH, in_ready);
    check_val("crypt_o", aes_ctrl_pkg::SP2V_LOW, crypt);
  endtask

  ////////////////////////////////////////
  // Watchdog and main sequence
  ////////////////////////////////////////

  always @(posedge clk) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run took more than %0d clock cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
    end
  end

  initial begin : main
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = aes_ctrl_pkg::SP2V_LOW;
    out_ready   = aes_ctrl_pkg::SP2V_LOW;
    key_len     = aes_ctrl_pkg::AES_128;
    op          = aes_ctrl_pkg::CIPH_FWD;
    cycle_cnt   = 0;
    lfsr_state  = 32'h7381;

    set_row(0, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_128, aes_ctrl_pkg::CIPH_FWD, 1'b0);
    set_row(1, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_192, aes_ctrl_pkg::CIPH_FWD, 1'b0);
    set_row(2, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_256, aes_ctrl_pkg::CIPH_FWD, 1'b0);
    set_row(3, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_128, aes_ctrl_pkg::CIPH_INV, 1'b0);
    set_row(4, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_192, aes_ctrl_pkg::CIPH_INV, 1'b0);
    set_row(5, aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::AES_256, aes_ctrl_pkg::CIPH_INV, 1'b0);
    set_row(6, 3'b111, aes_ctrl_pkg::AES_128, aes_ctrl_pkg::CIPH_FWD, 1'b1); // Bad sparse code
    set_row(7, aes_ctrl_pkg::SP2V_HIGH, 3'b011, aes_ctrl_pkg::CIPH_FWD, 1'b1); // Not one-hot

    cycle_limit = RstCycles;
    for (int i = 0; i < NumRows; i++) begin
      cycle_limit += rounds_for(row_key_len[i]) + int'(row_delay[i]) + 4;
    end

    repeat (RstCycles) next_cycle();
    rst_n = 1'b1;
    check_val("in_ready_o", aes_ctrl_pkg::SP2V_HIGH, in_ready);
    check_val("out_valid_o", aes_ctrl_pkg::SP2V_LOW, out_valid);
    check_val("crypt_o", aes_ctrl_pkg::SP2V_LOW, crypt);
    check_val("state_we_o", aes_ctrl_pkg::SP2V_LOW, state_we);
    check_val("key_expand_en_o", aes_ctrl_pkg::SP2V_LOW, key_expand_en);
    check_val("alert_o", 0, alert);

    for (int i = 0; i < NumRows; i++) begin
      if (row_alert[i]) begin
        run_fault(i);
      end else begin
        run_block(i);
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- aes_cipher_control.f
aes_ctrl_pkg.sv
aes_sp2v_chk.sv
aes_rail_combine.sv
aes_ctrl_rail.sv
aes_cipher_control.sv
aes_cipher_control_props.sv
aes_cipher_control_tb.sv
